// File: Makefile
# Verilator build and run for the system mapper testbench

VERILATOR ?= verilator
TOP       ?= tb_sys_map
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= RESULT: PASS

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: bench/tb_sys_map.sv
`timescale 1ns/100ps

module tb_sys_map;
	import map_pkg::*;
	import vram_pkg::*;

	localparam int TMR_GAP  = 52000;  // a little over one ms of clocks
	localparam int TMR_GAPS = 3;
	localparam int LIMIT    = TMR_GAPS * TMR_GAP + 40000;  // register and fetch traffic is under 20k

	localparam int E_PRG  = 0;
	localparam int E_REG  = 1;
	localparam int E_VRAM = 2;
	localparam int E_PPU  = 3;
	localparam int E_CHR  = 4;
	localparam int E_TMR  = 5;

	logic       clk = 1'b0;
	logic       rst;
	cpu_bus_t   cpu;
	ppu_bus_t   ppu;
	sys_cfg_t   cfg;
	map_out_t   map_o;
	logic [7:0] cpu_dout;
	logic       cpu_oe;
	logic [7:0] ppu_dout;
	logic       ppu_oe;

	logic [3:0]  bank_m;
	logic        off_m;
	logic [15:0] vaddr_m;
	logic [1:0]  mode_m;
	logic [3:0]  atr_cur_m;
	logic [7:0]  ntb_m [2048];
	logic [3:0]  atr_m [2048];
	logic [10:0] tile_m;  // last nametable tile fetched by the ppu
	int          cycles = 0;
	int          errs [6];

	sys_map u_dut (
		.clk(clk), .rst(rst), .cpu(cpu), .ppu(ppu), .cfg(cfg), .map(map_o),
		.cpu_dout(cpu_dout), .cpu_oe(cpu_oe), .ppu_dout(ppu_dout), .ppu_oe(ppu_oe)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT)
		begin
			$display("timeout: run did not finish within %0d cycles", LIMIT);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	task automatic check(input int area, input logic [31:0] got, input logic [31:0] exp,
		input string what);
		assert (got == exp)
		else
		begin
			errs[area]++;
			$display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	function automatic logic [7:0] rand_attr();
		logic [7:0] d;
		d = 8'($urandom());
		if (d[7:4] == MODE_KEY)
			d[7:4] = 4'h0;  // keep it an attribute write
		return d;
	endfunction

	task automatic set_cfg(input logic os, input logic rs);
		@(posedge clk);
		#10;
		cfg.os_act  = os;
		cfg.sys_rst = rs;
	endtask

	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		@(posedge clk);
		#10;
		cpu.addr = a;
		cpu.dat  = d;
		cpu.rw   = 1'b0;
		cpu.cyc  = 1'b1;
		@(posedge clk);
		#10;
		cpu.cyc = 1'b0;  // idle cycle follows
	endtask

	task automatic cpu_read(input logic [15:0] a, output logic [7:0] d, output logic oe);
		@(posedge clk);
		#10;
		cpu.addr = a;
		cpu.dat  = 8'h00;
		cpu.rw   = 1'b1;
		cpu.cyc  = 1'b1;
		@(negedge clk);
		d  = cpu_dout;
		oe = cpu_oe;
		@(posedge clk);
		#10;
		cpu.cyc = 1'b0;
	endtask

	// update the model, then put the write on the bus
	task automatic model_write(input logic [15:0] a, input logic [7:0] d);
		logic win;
		win = cfg.os_act && !cfg.sys_rst && a[15:8] == 8'h41;
		if (a == 16'h2001)
			off_m = !d[3];
		if (win && a[7:0] == 8'h06)
			bank_m = d[3:0];
		if (win && a[7:0] == 8'h00)
			vaddr_m[7:0] = d;
		if (win && a[7:0] == 8'h01)
			vaddr_m[15:8] = d;
		if (win && a[7:0] == 8'h03)
		begin
			if (d[7:4] != MODE_KEY)
				atr_cur_m = {d[5:4], d[1:0]};
			else if (d[1:0] != 2'd3)
				mode_m = d[1:0];
		end
		if (win && a[7:0] == 8'h02)
		begin
			if (!vaddr_m[15])
				ntb_m[vaddr_m[10:0]] = d;
			atr_m[vaddr_m[10:0]] = atr_cur_m;  // attribute always follows
		end
		if (a == 16'h2007 || (win && a[7:0] == 8'h02))
			vaddr_m = vaddr_m + 16'd1;
		cpu_write(a, d);
	endtask

	task automatic read_check(input int area, input logic [15:0] a, input logic [7:0] exp,
		input string what);
		logic [7:0] d;
		logic       oe;
		cpu_read(a, d, oe);
		check(area, 32'(oe), 32'd1, {what, " oe"});
		check(area, 32'(d), 32'(exp), what);
	endtask

	task automatic prg_check(input logic [15:0] a, input logic rw);
		logic        ram;
		logic        app;
		logic [16:0] lo;
		ram = a[15:12] == 4'h5;
		app = a[15:13] == 3'h3;
		if (ram)
			lo = {5'd0, a[11:0]};
		else if (app)
			lo = {bank_m, a[12:0]};
		else
			lo = {2'b11, a[14:0]};
		@(posedge clk);
		#10;
		cpu.addr = a;
		cpu.rw   = rw;
		@(negedge clk);
		check(E_PRG, 32'(map_o.prg_addr), 32'({6'h3F, lo}), "prg_addr");
		check(E_PRG, 32'({map_o.prg_ce, map_o.prg_we}),
			32'({a[15] || ram || app, !rw && (ram || app)}), "prg_ce/prg_we");
	endtask

	task automatic chr_check(input logic [13:0] a, input logic we);
		logic        ce_n;
		logic [22:0] chr;
		chr = {(off_m ? 6'h00 : 6'h3F), 4'd0, a[12:0]};
		if (off_m && mode_m != TST)
			ce_n = !a[13];  // loader owns the nametables through ciram
		else
			ce_n = !(a[13] && mode_m == SAF);
		@(posedge clk);
		#10;
		ppu.addr = a;
		ppu.we   = we;
		@(negedge clk);
		check(E_CHR, 32'(map_o.chr_addr), 32'(chr), "chr_addr");
		check(E_CHR, 32'({map_o.chr_ce, map_o.chr_we, map_o.ciram_a10, map_o.ciram_ce}),
			32'({!a[13], we && off_m, a[10], ce_n}), "chr_ce/chr_we/a10/ciram_ce");
	endtask

	task automatic fetch_check(input logic [13:0] a);
		logic [10:0] idx;
		logic        attr;
		logic [7:0]  exp;
		idx  = {a[11], a[9:0]};
		attr = a[13] && a[9:6] == 4'hF;
		exp  = attr ? {4{atr_m[tile_m][1:0]}} : ntb_m[idx];
		if (a[13] && !attr)
			tile_m = idx;
		@(posedge clk);
		#10;
		ppu.addr = a;
		ppu.rd   = 1'b1;
		@(posedge clk);
		#10;
		ppu.rd = 1'b0;
		@(negedge clk);  // data is valid the cycle after the strobe
		check(E_PPU, 32'(ppu_dout), 32'(exp), "ppu_dout");
		check(E_PPU, 32'(ppu_oe), 32'(a[13] && !off_m && mode_m == STD), "ppu_oe");
	endtask

	task automatic timer_read(output logic [15:0] cnt, output int at);
		logic [7:0] lo;
		logic [7:0] hi;
		logic       oe;
		at = cycles;
		cpu_read(16'h4104, lo, oe);
		cpu_read(16'h4105, hi, oe);
		cnt = {hi, lo};
	endtask

	initial
	begin
		logic        os;
		logic        rs;
		logic [7:0]  d;
		logic        oe;
		logic [15:0] start;
		logic [15:0] a;
		logic [13:0] pa;
		logic [15:0] c0;
		logic [15:0] c1;
		int          t0;
		int          t1;
		int          len;
		int          dms;
		int          ems;
		int          total;

		void'($urandom(32'h162f));
		rst = 1'b1;
		cpu = '0;
		ppu = '0;
		cfg.os_act  = 1'b1;
		cfg.sys_rst = 1'b0;
		bank_m    = 4'd0;
		off_m     = 1'b0;
		vaddr_m   = 16'd0;
		mode_m    = STD;
		atr_cur_m = 4'd0;
		for (int i = 0; i < 6; i++)
			errs[i] = 0;
		repeat (5) @(posedge clk);
		#10;
		rst = 1'b0;
		@(negedge clk);
		check(E_REG, 32'({cpu_oe, ppu_oe}), 32'd0, "oe after reset");
		chr_check(14'h2400, 1'b0);  // ppu_off clear and std mode out of reset

		// bank register, window gating and prg mapping
		for (int i = 0; i < 60; i++)
		begin
			os = 1'($urandom());
			rs = ($urandom() % 4 == 0);
			set_cfg(os, rs);
			model_write(16'h4106, 8'($urandom()));
			cpu_read(16'h4106, d, oe);
			check(E_REG, 32'(oe), 32'(os && !rs), "cpu_oe on bank read");
			set_cfg(1'b1, 1'b0);
			read_check(E_REG, 16'h4106, {4'd0, bank_m}, "bank read-back");
			repeat (5) prg_check(16'($urandom()), 1'($urandom()));
		end

		// fill the whole vram so every ppu fetch has a known value
		model_write(16'h4100, 8'h00);
		model_write(16'h4101, 8'h00);
		for (int i = 0; i < 2048; i++)
		begin
			if ($urandom() % 4 == 0)
				model_write(16'h4103, rand_attr());
			model_write(16'h4102, 8'($urandom()));
		end
		for (int i = 0; i < 30; i++)
		begin
			start = 16'($urandom());
			len   = 1 + int'($urandom() % 12);
			model_write(16'h4100, start[7:0]);
			model_write(16'h4101, start[15:8]);
			for (int j = 0; j < len; j++)
			begin
				if ($urandom() % 3 == 0)
					model_write(16'h4103, rand_attr());
				if ($urandom() % 6 == 0)
					model_write(16'h2007, 8'($urandom()));  // ppu data port also steps
				else
					model_write(16'h4102, 8'($urandom()));
			end
			read_check(E_VRAM, 16'h4100, vaddr_m[7:0], "vram addr lo");
			read_check(E_VRAM, 16'h4101, vaddr_m[15:8], "vram addr hi");
			for (int j = 0; j < len; j++)
			begin
				a = start + 16'(j);
				model_write(16'h4100, a[7:0]);
				model_write(16'h4101, a[15:8]);
				read_check(E_VRAM, 16'h4102, ntb_m[a[10:0]], "vram data");
				atr_cur_m = atr_m[a[10:0]];
			end
		end

		// chr and ciram mapping under ppu_off and mode changes
		for (int i = 0; i < 40; i++)
		begin
			model_write(16'h2001, 8'($urandom()));
			model_write(16'h4103, {MODE_KEY, 4'($urandom())});
			repeat (4) chr_check(14'($urandom()), 1'($urandom()));
		end

		// the first ppu fetch sets up the attribute tile
		fetch_check(14'h2000);
		for (int i = 0; i < 400; i++)
		begin
			if (i % 25 == 24)
			begin
				model_write(16'h2001, 8'($urandom()));
				model_write(16'h4103, {MODE_KEY, 4'($urandom())});
			end
			pa     = 14'($urandom());
			pa[13] = ($urandom() % 8 != 0);
			if ($urandom() % 3 == 0)
				pa[9:6] = 4'hF;
			fetch_check(pa);
		end

		timer_read(c0, t0);
		for (int i = 0; i < TMR_GAPS; i++)
		begin
			repeat (TMR_GAP) @(posedge clk);
			timer_read(c1, t1);
			dms = int'(c1) - int'(c0);
			ems = (t1 - t0) / CLK_PER_MS;
			assert (c1 >= c0)
			else
			begin
				errs[E_TMR]++;
				$display("** Error at %0t ns: ms count fell from %0d to %0d", $time, c0, c1);
			end
			assert (dms >= ems - 1 && dms <= ems + 1)
			else
			begin
				errs[E_TMR]++;
				$display("** Error at %0t ns: ms count moved %0d, expected %0d within one",
					$time, dms, ems);
			end
			c0 = c1;
			t0 = t1;
		end

		total = 0;
		for (int i = 0; i < 6; i++)
			total += errs[i];
		$display("errors: prg %0d, reg %0d, vram %0d, ppu %0d, chr %0d, timer %0d, total %0d",
			errs[E_PRG], errs[E_REG], errs[E_VRAM], errs[E_PPU], errs[E_CHR], errs[E_TMR], total);
		if (total == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: common/map_pkg.sv
package map_pkg;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dat;
		logic        rw;   // 1 = read
		logic        cyc;  // one-cycle bus transaction strobe
	} cpu_bus_t;

	typedef struct packed {
		logic [13:0] addr;
		logic        rd;   // one-cycle fetch strobe
		logic        we;   // write level
	} ppu_bus_t;

	typedef struct packed {
		logic os_act;      // register window enabled
		logic sys_rst;     // register window blocked
	} sys_cfg_t;

	typedef struct packed {
		logic [22:0] prg_addr;
		logic        prg_ce;
		logic        prg_we;
		logic [22:0] chr_addr;
		logic        chr_ce;
		logic        chr_we;
		logic        ciram_a10;
		logic        ciram_ce;  // active low
	} map_out_t;

	// offsets inside the 0x41xx window
	localparam logic [7:0] REG_VRAM_CTRL = 8'd0;  // four registers
	localparam logic [7:0] REG_TIMER     = 8'd4;  // two registers
	localparam logic [7:0] REG_APP_BANK  = 8'd6;

	localparam logic [7:0] REG_BASE = 8'h41;
	localparam logic [3:0] RAM_BASE = 4'h5;
	localparam logic [2:0] APP_BASE = 3'h3;  // 0x6000-0x7fff

	localparam logic [5:0] SYS_BANK = 6'h3F;  // system rom sits at 0x7e0000

	localparam int CLK_PER_MS = 50000;
	localparam int MS_CNT_W   = $clog2(CLK_PER_MS);

endpackage

// File: common/vram_pkg.sv
package vram_pkg;

	localparam logic [1:0] REG_VRM_ADDR_LO = 2'd0;
	localparam logic [1:0] REG_VRM_ADDR_HI = 2'd1;
	localparam logic [1:0] REG_VRM_DATA    = 2'd2;
	localparam logic [1:0] REG_VRM_ATTR    = 2'd3;

	typedef enum logic [1:0] {
		STD = 2'd0,
		SAF = 2'd1,
		TST = 2'd2
	} vram_mode_t;

	localparam logic [3:0] MODE_KEY = 4'hA;  // high nibble of a mode write

	localparam int VRAM_AW = 11;

	typedef logic [7:0] ntb_word_t;
	typedef logic [3:0] atr_word_t;

	typedef struct packed {
		logic ppu_off_tst;  // TST mode
		logic saf;          // SAF mode
	} vram_ctl_t;

	typedef struct packed {
		logic [VRAM_AW-1:0] addr;
		ntb_word_t          data;
		logic               we;
	} ntb_wr_t;

	typedef struct packed {
		logic [VRAM_AW-1:0] addr;
		atr_word_t          data;
		logic               we;
	} atr_wr_t;

endpackage

// File: filelist.f
common/map_pkg.sv
common/vram_pkg.sv
source/map_decode.sv
source/ms_timer.sv
vram/vram_regs.sv
vram/ram_dp.sv
vram/ppu_fetch.sv
source/sys_map.sv
bench/tb_sys_map.sv

// File: source/map_decode.sv
`timescale 1ns/100ps

module map_decode (
	input  logic                clk,
	input  logic                rst,
	input  map_pkg::cpu_bus_t   cpu,
	input  map_pkg::ppu_bus_t   ppu,
	input  map_pkg::sys_cfg_t   cfg,
	input  logic [7:0]          vram_rd,
	input  logic [7:0]          timer_rd,
	input  vram_pkg::vram_ctl_t vram_ctl,
	input  logic                ppu_hit,
	output logic                vram_sel,
	output logic                timer_sel,
	output logic                ppu_off,
	output map_pkg::map_out_t   map,
	output logic [7:0]          cpu_dout,
	output logic                cpu_oe,
	output logic                ppu_oe
);
	import map_pkg::*;

	logic        reg_area;
	logic        ram_area;
	logic        app_area;
	logic        rom_area;
	logic        regs_ce;
	logic        bank_sel;
	logic        cpu_wr;
	logic [7:0]  reg_addr;
	logic [3:0]  app_bank;
	logic [16:0] prg_lo;

	assign reg_area = (cpu.addr[15:8] == REG_BASE);
	assign ram_area = (cpu.addr[15:12] == RAM_BASE);
	assign app_area = (cpu.addr[15:13] == APP_BASE);
	assign rom_area = cpu.addr[15];
	assign reg_addr = cpu.addr[7:0];
	assign cpu_wr   = cpu.cyc & !cpu.rw;

	assign regs_ce   = reg_area & cfg.os_act & !cfg.sys_rst;
	assign vram_sel  = regs_ce & ({reg_addr[7:2], 2'b00} == REG_VRAM_CTRL);
	assign timer_sel = regs_ce & ({reg_addr[7:1], 1'b0} == REG_TIMER);
	assign bank_sel  = regs_ce & (reg_addr == REG_APP_BANK);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			app_bank <= 4'd0;
			ppu_off  <= 1'b0;
		end
		else
		begin
			if (cpu_wr & bank_sel)
				app_bank <= cpu.dat[3:0];
			if (cpu_wr & (cpu.addr == 16'h2001))
				ppu_off <= !cpu.dat[3];  // rendering off hands vram to the loader
		end
	end

	always_comb
	begin
		if (ram_area)
			prg_lo = {5'd0, cpu.addr[11:0]};
		else if (app_area)
			prg_lo = {app_bank, cpu.addr[12:0]};
		else
			prg_lo = {2'b11, cpu.addr[14:0]};  // top 32k of the system bank
	end

	always_comb
	begin
		map.prg_addr  = {SYS_BANK, prg_lo};
		map.prg_ce    = rom_area | ram_area | app_area;
		map.prg_we    = (ram_area | app_area) & !cpu.rw;
		map.chr_addr  = {(ppu_off ? 6'h00 : SYS_BANK), 4'd0, ppu.addr[12:0]};
		map.chr_ce    = !ppu.addr[13];
		map.chr_we    = ppu.we & ppu_off;  // chr ram writable only with ppu off
		map.ciram_a10 = ppu.addr[10];
		// active-low ciram gives way to the internal vram outside ppu_off
		if (ppu_off & !vram_ctl.ppu_off_tst)
			map.ciram_ce = !ppu.addr[13];
		else
			map.ciram_ce = !(ppu.addr[13] & vram_ctl.saf);
	end

	always_comb
	begin
		if (bank_sel)
			cpu_dout = {4'd0, app_bank};
		else if (timer_sel)
			cpu_dout = timer_rd;
		else if (vram_sel)
			cpu_dout = vram_rd;
		else
			cpu_dout = 8'h00;
	end

	assign cpu_oe = regs_ce & cpu.rw & cpu.cyc;
	assign ppu_oe = ppu_hit & !vram_ctl.saf & !vram_ctl.ppu_off_tst;  // std mode only

	// a register read never drives the bus while a prg chip is enabled
	a_oe_in_regs: assert property (@(posedge clk) disable iff (rst)
		$rose(cpu_oe) |-> !map.prg_ce);

endmodule

// File: source/ms_timer.sv
`timescale 1ns/100ps

module ms_timer (
	input  logic              clk,
	input  logic              rst,
	input  map_pkg::cpu_bus_t cpu,
	input  logic              timer_sel,
	output logic [7:0]        timer_rd
);
	import map_pkg::*;

	logic [MS_CNT_W-1:0] presc;
	logic                tick;
	logic [15:0]         ms_cnt;
	logic [7:0]          ms_hi;
	logic                lo_rd;

	assign lo_rd    = timer_sel & cpu.cyc & cpu.rw & !cpu.addr[0];
	assign timer_rd = cpu.addr[0] ? ms_hi : ms_cnt[7:0];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			presc  <= '0;
			tick   <= 1'b0;
			ms_cnt <= 16'd0;
			ms_hi  <= 8'd0;
		end
		else
		begin
			tick <= 1'b0;
			if (presc == MS_CNT_W'(CLK_PER_MS - 1))
			begin
				presc <= '0;
				tick  <= 1'b1;  // one pulse per ms
			end
			else
				presc <= presc + 1'b1;
			if (tick)
				ms_cnt <= ms_cnt + 16'd1;
			if (lo_rd)
				ms_hi <= ms_cnt[15:8];  // freeze high byte so lo/hi pair is coherent
		end
	end

	a_presc_range: assert property (@(posedge clk) disable iff (rst)
		presc < MS_CNT_W'(CLK_PER_MS));

endmodule

// File: source/sys_map.sv
`timescale 1ns/100ps

module sys_map (
	input  logic                clk,
	input  logic                rst,
	input  map_pkg::cpu_bus_t   cpu,
	input  map_pkg::ppu_bus_t   ppu,
	input  map_pkg::sys_cfg_t   cfg,
	output map_pkg::map_out_t   map,
	output logic [7:0]          cpu_dout,
	output logic                cpu_oe,
	output logic [7:0]          ppu_dout,
	output logic                ppu_oe
);
	import vram_pkg::*;

	logic               vram_sel;
	logic               timer_sel;
	logic               ppu_off;
	logic               ppu_hit;
	logic [7:0]         vram_rd;
	logic [7:0]         timer_rd;
	vram_ctl_t          vram_ctl;
	ntb_wr_t            ntb_a;
	atr_wr_t            atr_a;
	ntb_word_t          ntb_qa;
	ntb_word_t          ntb_qb;
	atr_word_t          atr_qa;
	atr_word_t          atr_qb;
	logic [VRAM_AW-1:0] ntb_b_addr;
	logic [VRAM_AW-1:0] atr_b_addr;

	map_decode u_decode (
		.clk(clk), .rst(rst), .cpu(cpu), .ppu(ppu), .cfg(cfg),
		.vram_rd(vram_rd), .timer_rd(timer_rd), .vram_ctl(vram_ctl), .ppu_hit(ppu_hit),
		.vram_sel(vram_sel), .timer_sel(timer_sel), .ppu_off(ppu_off), .map(map),
		.cpu_dout(cpu_dout), .cpu_oe(cpu_oe), .ppu_oe(ppu_oe)
	);

	ms_timer u_timer (
		.clk(clk), .rst(rst), .cpu(cpu), .timer_sel(timer_sel), .timer_rd(timer_rd)
	);

	vram_regs u_vram_regs (
		.clk(clk), .rst(rst), .cpu(cpu), .vram_sel(vram_sel),
		.ntb_q(ntb_qa), .atr_q(atr_qa), .ntb_a(ntb_a), .atr_a(atr_a),
		.vram_rd(vram_rd), .vram_ctl(vram_ctl)
	);

	ram_dp #(.word_t(ntb_word_t)) u_ntb_ram (
		.clk(clk), .addr_a(ntb_a.addr), .din_a(ntb_a.data), .we_a(ntb_a.we),
		.dout_a(ntb_qa), .addr_b(ntb_b_addr), .dout_b(ntb_qb)
	);

	ram_dp #(.word_t(atr_word_t)) u_atr_ram (
		.clk(clk), .addr_a(atr_a.addr), .din_a(atr_a.data), .we_a(atr_a.we),
		.dout_a(atr_qa), .addr_b(atr_b_addr), .dout_b(atr_qb)
	);

	ppu_fetch u_fetch (
		.clk(clk), .rst(rst), .ppu(ppu), .ppu_off(ppu_off),
		.ntb_q(ntb_qb), .atr_q(atr_qb), .ntb_b_addr(ntb_b_addr), .atr_b_addr(atr_b_addr),
		.ppu_dout(ppu_dout), .ppu_hit(ppu_hit)
	);

endmodule

// File: vram/ppu_fetch.sv
`timescale 1ns/100ps

module ppu_fetch (
	input  logic                         clk,
	input  logic                         rst,
	input  map_pkg::ppu_bus_t            ppu,
	input  logic                         ppu_off,
	input  vram_pkg::ntb_word_t          ntb_q,
	input  vram_pkg::atr_word_t          atr_q,
	output logic [vram_pkg::VRAM_AW-1:0] ntb_b_addr,
	output logic [vram_pkg::VRAM_AW-1:0] atr_b_addr,
	output logic [7:0]                   ppu_dout,
	output logic                         ppu_hit
);
	logic ntb_ce;
	logic atr_ce;
	logic atr_sel;

	assign ntb_b_addr = {ppu.addr[11], ppu.addr[9:0]};  // a11 selects one of two screens
	assign atr_ce     = ppu.addr[13] & (ppu.addr[9:6] == 4'hF);
	assign ntb_ce     = ppu.addr[13] & (ppu.addr[9:6] != 4'hF);

	// the tile just fetched owns the next attribute fetch
	always_ff @(posedge clk)
	begin
		if (ppu.rd & ntb_ce)
			atr_b_addr <= ntb_b_addr;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			atr_sel <= 1'b0;
			ppu_hit <= 1'b0;
		end
		else
		begin
			if (ppu.rd)
				atr_sel <= atr_ce;
			ppu_hit <= ppu.rd & ppu.addr[13] & !ppu_off;
		end
	end

	// per-tile palette bits repeated over all four quadrants
	assign ppu_dout = atr_sel ? {4{atr_q[1:0]}} : ntb_q;

endmodule

// File: vram/ram_dp.sv
`timescale 1ns/100ps

module ram_dp #(
	parameter type word_t = logic [7:0]
) (
	input  logic                         clk,
	input  logic [vram_pkg::VRAM_AW-1:0] addr_a,
	input  word_t                        din_a,
	input  logic                         we_a,
	output word_t                        dout_a,
	input  logic [vram_pkg::VRAM_AW-1:0] addr_b,
	output word_t                        dout_b
);
	import vram_pkg::*;

	word_t mem [2**VRAM_AW];

	// cpu side port a returns old data on a write
	always_ff @(posedge clk)
	begin
		if (we_a)
			mem[addr_a] <= din_a;
		dout_a <= mem[addr_a];
	end

	always_ff @(posedge clk)
	begin
		dout_b <= mem[addr_b];  // read-only ppu side
	end

endmodule

// File: vram/vram_regs.sv
`timescale 1ns/100ps

module vram_regs (
	input  logic                clk,
	input  logic                rst,
	input  map_pkg::cpu_bus_t   cpu,
	input  logic                vram_sel,
	input  vram_pkg::ntb_word_t ntb_q,
	input  vram_pkg::atr_word_t atr_q,
	output vram_pkg::ntb_wr_t   ntb_a,
	output vram_pkg::atr_wr_t   atr_a,
	output logic [7:0]          vram_rd,
	output vram_pkg::vram_ctl_t vram_ctl
);
	import vram_pkg::*;

	logic        cpu_wr;
	logic        cpu_rd;
	logic        ce_lo;
	logic        ce_hi;
	logic        ce_data;
	logic        ce_attr;
	logic        ppu_dat_ce;
	logic        mode_wr;
	logic [15:0] vaddr;
	atr_word_t   cur_atr;
	vram_mode_t  mode;

	assign cpu_wr     = cpu.cyc & !cpu.rw;
	assign cpu_rd     = cpu.cyc & cpu.rw;
	assign ce_lo      = vram_sel & (cpu.addr[1:0] == REG_VRM_ADDR_LO);
	assign ce_hi      = vram_sel & (cpu.addr[1:0] == REG_VRM_ADDR_HI);
	assign ce_data    = vram_sel & (cpu.addr[1:0] == REG_VRM_DATA);
	assign ce_attr    = vram_sel & (cpu.addr[1:0] == REG_VRM_ATTR);
	assign ppu_dat_ce = (cpu.addr == 16'h2007);  // shadow the ppu data port
	assign mode_wr    = cpu_wr & ce_attr & (cpu.dat[7:4] == MODE_KEY);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			vaddr   <= 16'd0;
			cur_atr <= '0;
			mode    <= STD;
		end
		else
		begin
			if (cpu_wr & ce_lo)
				vaddr[7:0] <= cpu.dat;
			if (cpu_wr & ce_hi)
				vaddr[15:8] <= cpu.dat;
			if (cpu_wr & (ce_data | ppu_dat_ce))
				vaddr <= vaddr + 16'd1;
			if (cpu_rd & ce_data)
				cur_atr <= atr_q;  // back buffer copy picks up the stored attribute
			if (cpu_wr & ce_attr & (cpu.dat[7:4] != MODE_KEY))
				cur_atr <= {cpu.dat[5:4], cpu.dat[1:0]};
			if (mode_wr & (cpu.dat[1:0] != 2'd3))
				mode <= vram_mode_t'(cpu.dat[1:0]);  // code 3 unused
		end
	end

	// bit 15 set lets attributes change while the nametable stays put
	assign ntb_a.addr = vaddr[VRAM_AW-1:0];
	assign ntb_a.data = cpu.dat;
	assign ntb_a.we   = cpu_wr & ce_data & !vaddr[15];

	assign atr_a.addr = vaddr[VRAM_AW-1:0];
	assign atr_a.data = cur_atr;
	assign atr_a.we   = cpu_wr & ce_data;

	always_comb
	begin
		if (ce_lo)
			vram_rd = vaddr[7:0];
		else if (ce_hi)
			vram_rd = vaddr[15:8];
		else if (ce_data)
			vram_rd = ntb_q;
		else
			vram_rd = 8'h00;
	end

	assign vram_ctl.ppu_off_tst = (mode == TST);
	assign vram_ctl.saf         = (mode == SAF);

	// a longer strobe would write twice and step the address twice
	a_we_single: assert property (@(posedge clk) disable iff (rst)
		(ntb_a.we || atr_a.we) |-> vram_sel && !$past(atr_a.we));

endmodule
